/* flist.f */
rtl/exec_pkg.sv
rtl/exec_dispatch.sv
rtl/exec_alu.sv
rtl/exec_lane.sv
rtl/exec_retire.sv
rtl/exec_cluster.sv
verif/exec_assert.sv
verif/exec_tb.sv

/* verif/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb;

  localparam int NUM_LANES = 4;
  localparam int TIMEOUT   = 20;

  typedef exec_pkg::exec_slot_t [NUM_LANES-1:0] slot_pkt_t;
  typedef exec_pkg::wb_slot_t   [NUM_LANES-1:0] wb_pkt_t;

  logic                             clk;
  logic                             rst;
  logic                             issue_strobe;
  slot_pkt_t                        issue_slots;
  logic                             wb_strobe;
  logic [$clog2(NUM_LANES + 1)-1:0] wb_count;
  wb_pkt_t                          wb_slots;
  logic [31:0]                      csr_out;

  // Reference model state and expected packets in issue order
  logic [31:0] model_csr;
  wb_pkt_t     exp_q[$];
  int          cnt_q[$];
  logic [31:0] csr_q[$];
  int          err_cnt;
  int          test_cnt;
  int          test_err;

  exec_cluster #(
    .NUM_LANES (NUM_LANES)
  ) dut (
    .clk          (clk),
    .rst          (rst),
    .issue_strobe (issue_strobe),
    .issue_slots  (issue_slots),
    .wb_strobe    (wb_strobe),
    .wb_count     (wb_count),
    .wb_slots     (wb_slots),
    .csr_out      (csr_out)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic exec_pkg::wb_slot_t slot_result(input exec_pkg::exec_slot_t s,
                                                     input logic [31:0] csr);
    exec_pkg::wb_slot_t r;
    // Compare bit for every kind
    r.comp = (s.a < s.b);
    case (s.kind)
      exec_pkg::ADD:   r.res = s.a + s.b;
      exec_pkg::SUB:   r.res = s.a - s.b;
      exec_pkg::AND:   r.res = s.a & s.b;
      exec_pkg::OR:    r.res = s.a | s.b;
      exec_pkg::XOR:   r.res = s.a ^ s.b;
      exec_pkg::SLL:   r.res = s.a << s.b[4:0];
      exec_pkg::SRL:   r.res = s.a >> s.b[4:0];
      exec_pkg::SRA:   r.res = $signed(s.a) >>> s.b[4:0];
      exec_pkg::SLTU:  r.res = {31'b0, r.comp};
      exec_pkg::LUI:   r.res = s.b;
      exec_pkg::AUIPC: r.res = s.b + {20'b0, s.pc[11:0]};
      exec_pkg::JAL,
      exec_pkg::JALR:  r.res = s.pc + 32'd4;
      // CSR kinds hand back the old value
      default:         r.res = csr;
    endcase
    return r;
  endfunction

  task automatic queue_expected(input slot_pkt_t pkt);
    wb_pkt_t     e;
    int          n;
    logic [31:0] next_csr;
    e        = '0;
    n        = 0;
    next_csr = model_csr;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (pkt[i].valid)
      begin
        e[n] = slot_result(pkt[i], model_csr);
        n++;
        // Ascending scan lets the highest CSR slot win
        case (pkt[i].kind)
          exec_pkg::CSRRW: next_csr = pkt[i].a;
          exec_pkg::CSRRS: next_csr = model_csr | pkt[i].a;
          exec_pkg::CSRRC: next_csr = model_csr & ~pkt[i].a;
          default:         next_csr = next_csr;
        endcase
      end
    end
    model_csr = next_csr;
    exp_q.push_back(e);
    cnt_q.push_back(n);
    csr_q.push_back(next_csr);
  endtask

  ////////////////////////////////////////
  // Drive and check helpers
  ////////////////////////////////////////

  function automatic exec_pkg::exec_slot_t make_slot(input exec_pkg::exec_kind_e k,
                                                     input logic [31:0] a,
                                                     input logic [31:0] b);
    exec_pkg::exec_slot_t s;
    s.valid = 1'b1;
    s.kind  = k;
    s.a     = a;
    s.b     = b;
    s.pc    = $urandom & 32'hffff_fffc;
    return s;
  endfunction

  task automatic issue(input slot_pkt_t pkt);
    @(negedge clk);
    issue_strobe = 1'b1;
    issue_slots  = pkt;
    queue_expected(pkt);
  endtask

  // Wait for write-back while counting falling edges
  task automatic wait_wb(output int cyc);
    cyc = 0;
    while (!wb_strobe)
    begin
      if (cyc == TIMEOUT)
      begin
        $display("Timeout after %0d cycles waiting for wb_strobe", TIMEOUT);
        $display("*** FAILED ***");
        $finish;
      end
      @(negedge clk);
      cyc++;
    end
  endtask

  task automatic check_wb;
    wb_pkt_t     e;
    int          n;
    logic [31:0] c;
    if (exp_q.size() == 0)
    begin
      $display("Write-back at %0t with no packet in flight", $time);
      err_cnt++;
      return;
    end
    e = exp_q.pop_front();
    n = cnt_q.pop_front();
    c = csr_q.pop_front();
    if (wb_count !== n)
    begin
      $display("Error at %0t: wb_count %0d, expected %0d", $time, wb_count, n);
      err_cnt++;
    end
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (wb_slots[i] !== e[i])
      begin
        $display("Error at %0t: wb_slots[%0d] %h, expected %h", $time, i, wb_slots[i], e[i]);
        err_cnt++;
      end
    end
    if (csr_out !== c)
    begin
      $display("Error at %0t: csr_out %h, expected %h", $time, csr_out, c);
      err_cnt++;
    end
  endtask

  // Single packet drained before returning
  task automatic run_packet(input slot_pkt_t pkt);
    int lat;
    issue(pkt);
    @(negedge clk);
    issue_strobe = 1'b0;
    wait_wb(lat);
    if (lat + 1 != 3)
    begin
      $display("Error at %0t: latency %0d cycles, expected 3", $time, lat + 1);
      err_cnt++;
    end
    check_wb();
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err)
      $display("Test %s: ok", name);
    else
      $display("Test %s: %0d errors", name, err_cnt - test_err);
    test_cnt++;
    test_err = err_cnt;
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_alu_random;
    slot_pkt_t p;
    for (int n = 0; n < 4; n++)
    begin
      for (int i = 0; i < NUM_LANES; i++)
        p[i] = make_slot(exec_pkg::exec_kind_e'($urandom_range(0, 4)), $urandom, $urandom);
      run_packet(p);
    end
    end_test("alu_random");
  endtask

  task automatic test_special_kinds;
    slot_pkt_t p;
    p[0] = make_slot(exec_pkg::SLL, $urandom, 32'd7);
    // Only b[4:0] counts as shift amount
    p[1] = make_slot(exec_pkg::SRL, 32'h8000_0f00, 32'h0000_0024);
    p[2] = make_slot(exec_pkg::SRA, 32'h9000_0000, 32'd5);
    p[3] = make_slot(exec_pkg::SLTU, 32'd3, 32'hffff_fff0);
    run_packet(p);
    p[0] = make_slot(exec_pkg::SLTU, 32'hffff_fff0, 32'd3);
    p[1] = make_slot(exec_pkg::LUI, $urandom, 32'habcd_e000);
    p[2] = make_slot(exec_pkg::AUIPC, $urandom, 32'h1234_5000);
    p[3] = make_slot(exec_pkg::JAL, $urandom, $urandom);
    run_packet(p);
    p[0] = make_slot(exec_pkg::JALR, $urandom, $urandom);
    p[1] = make_slot(exec_pkg::SRA, 32'hffff_ff00, 32'd31);
    p[2] = make_slot(exec_pkg::SRA, $urandom | 32'h8000_0000, $urandom);
    run_packet(p);
    end_test("special_kinds");
  endtask

  task automatic test_holes;
    slot_pkt_t  p;
    logic [3:0] mask [4] = '{4'b0101, 4'b1000, 4'b0110, 4'b0000};
    for (int n = 0; n < 4; n++)
    begin
      // Dead slots still carry operands
      for (int i = 0; i < NUM_LANES; i++)
      begin
        p[i]       = make_slot(exec_pkg::exec_kind_e'($urandom_range(0, 12)), $urandom, $urandom);
        p[i].valid = mask[n][i];
      end
      run_packet(p);
    end
    end_test("holes_and_empty");
  endtask

  task automatic test_csr;
    slot_pkt_t p;
    p    = '0;
    p[0] = make_slot(exec_pkg::CSRRW, 32'hf0f0_1234, $urandom);
    run_packet(p);
    p[0] = make_slot(exec_pkg::CSRRS, 32'h0000_00ff, $urandom);
    run_packet(p);
    p[0] = make_slot(exec_pkg::CSRRC, 32'hf000_000f, $urandom);
    run_packet(p);
    // Three writers in one packet where slot 3 wins
    p[0] = make_slot(exec_pkg::CSRRS, 32'h0000_ff00, $urandom);
    p[1] = make_slot(exec_pkg::ADD, $urandom, $urandom);
    p[2] = make_slot(exec_pkg::CSRRW, 32'h5555_aaaa, $urandom);
    p[3] = make_slot(exec_pkg::CSRRC, 32'h0f0f_0f0f, $urandom);
    run_packet(p);
    end_test("csr_forms");
  endtask

  task automatic test_back_to_back;
    slot_pkt_t p;
    int        lat;
    fork
      begin
        for (int n = 0; n < 8; n++)
        begin
          for (int i = 0; i < NUM_LANES; i++)
            p[i] = make_slot(exec_pkg::exec_kind_e'($urandom_range(0, 12)), $urandom, $urandom);
          issue(p);
        end
        @(negedge clk);
        issue_strobe = 1'b0;
      end
      begin
        @(negedge clk);
        wait_wb(lat);
        // First packet issued on the edge this wait started from
        if (lat != 3)
        begin
          $display("Error at %0t: first packet latency %0d cycles, expected 3", $time, lat);
          err_cnt++;
        end
        // One write-back per cycle without gaps
        for (int n = 0; n < 8; n++)
        begin
          if (!wb_strobe)
          begin
            $display("Write-back stream broke off at packet %0d", n);
            err_cnt++;
          end
          check_wb();
          @(negedge clk);
        end
      end
    join
    end_test("back_to_back");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    void'($urandom(32'hdfa0a84c));
    clk          = 1'b0;
    rst          = 1'b1;
    issue_strobe = 1'b0;
    issue_slots  = '0;
    model_csr    = '0;
    err_cnt      = 0;
    test_cnt     = 0;
    test_err     = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_alu_random();
    test_special_kinds();
    test_holes();
    test_csr();
    test_back_to_back();
    if (dut.u_assert.fail_cnt != 0)
    begin
      $display("Protocol assertions failed %0d times", dut.u_assert.fail_cnt);
      err_cnt += dut.u_assert.fail_cnt;
    end
    $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* verif/exec_assert.sv */
`timescale 1ns/1ps

module exec_assert #(
  parameter int NUM_LANES = 4
)
(
  input logic                              clk,
  input logic                              rst,
  input logic                              issue_strobe,
  input logic                              wb_strobe,
  input logic [$clog2(NUM_LANES + 1)-1:0]  wb_count
);

  // Failed assertion tally
  int fail_cnt = 0;

  ////////////////////////////////////////
  // Protocol properties
  ////////////////////////////////////////

  // No write-back while held in reset
  a_rst_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !wb_strobe)
  else
  begin
    $error("wb_strobe high during reset");
    fail_cnt++;
  end

  // Count bounded by the lane count
  a_count_max: assert property (@(posedge clk) disable iff (rst) wb_count <= NUM_LANES)
  else
  begin
    $error("wb_count %0d above lane count", wb_count);
    fail_cnt++;
  end

  // Fixed three stage latency, no back-pressure
  a_latency: assert property (@(posedge clk) disable iff (rst) issue_strobe |-> ##3 wb_strobe)
  else
  begin
    $error("wb_strobe missing 3 cycles after issue");
    fail_cnt++;
  end

endmodule

bind exec_cluster exec_assert #(
  .NUM_LANES (NUM_LANES)
) u_assert (
  .clk          (clk),
  .rst          (rst),
  .issue_strobe (issue_strobe),
  .wb_strobe    (wb_strobe),
  .wb_count     (wb_count)
);

/* rtl/exec_cluster.sv */
`timescale 1ns/1ps

module exec_cluster #(
  parameter int NUM_LANES = 4
)
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  issue_strobe,
  input  exec_pkg::exec_slot_t [NUM_LANES-1:0]  issue_slots,
  output logic                                  wb_strobe,
  output logic [$clog2(NUM_LANES + 1)-1:0]      wb_count,
  output exec_pkg::wb_slot_t   [NUM_LANES-1:0]  wb_slots,
  output logic [exec_pkg::XLEN-1:0]             csr_out
);

  // Stage 1 controls
  exec_pkg::lane_ctl_t [NUM_LANES-1:0] lane_ctl;
  logic                                disp_strobe;
  // Stage 2 results
  exec_pkg::lane_res_t [NUM_LANES-1:0] lane_res;
  // Shared CSR seen by every lane
  logic [exec_pkg::XLEN-1:0]           csr_value;

  exec_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .clk          (clk),
    .rst          (rst),
    .issue_strobe (issue_strobe),
    .issue_slots  (issue_slots),
    .lane_ctl     (lane_ctl),
    .disp_strobe  (disp_strobe)
  );

  ////////////////////////////////////////
  // Execute lanes
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_lane
    exec_lane u_lane (
      .clk       (clk),
      .rst       (rst),
      .ctl       (lane_ctl[i]),
      .csr_value (csr_value),
      .result    (lane_res[i])
    );
  end

  exec_retire #(
    .NUM_LANES (NUM_LANES)
  ) u_retire (
    .clk         (clk),
    .rst         (rst),
    .disp_strobe (disp_strobe),
    .lane_res    (lane_res),
    .csr_value   (csr_value),
    .wb_strobe   (wb_strobe),
    .wb_count    (wb_count),
    .wb_slots    (wb_slots),
    .csr_out     (csr_out)
  );

endmodule

/* rtl/exec_retire.sv */
`timescale 1ns/1ps

module exec_retire #(
  parameter int NUM_LANES = 4
)
(
  input  logic                                  clk,
  input  logic                                  rst,
  // Stage 1 packet marker from dispatch
  input  logic                                  disp_strobe,
  input  exec_pkg::lane_res_t [NUM_LANES-1:0]   lane_res,
  output logic [exec_pkg::XLEN-1:0]             csr_value,
  output logic                                  wb_strobe,
  output logic [$clog2(NUM_LANES + 1)-1:0]      wb_count,
  output exec_pkg::wb_slot_t  [NUM_LANES-1:0]   wb_slots,
  output logic [exec_pkg::XLEN-1:0]             csr_out
);

  localparam int CNT_W = $clog2(NUM_LANES + 1);

  // Packet marker for stage 2
  logic                               s2_strobe;
  // Target index of each lane in the packet
  logic [CNT_W-1:0]                   pos [NUM_LANES];
  logic [CNT_W-1:0]                   cnt_d;
  exec_pkg::wb_slot_t [NUM_LANES-1:0] slots_d;
  logic [exec_pkg::XLEN-1:0]          csr_q;
  logic [exec_pkg::XLEN-1:0]          csr_next;

  ////////////////////////////////////////
  // Compaction
  ////////////////////////////////////////

  // Running count of valid lanes below each lane
  always_comb
  begin
    cnt_d = '0;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      pos[i] = cnt_d;
      if (lane_res[i].valid)
        cnt_d = cnt_d + 1'b1;
    end
  end

  // Scatter valid results to their packed index, rest stay zero
  always_comb
  begin
    slots_d = '0;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (lane_res[i].valid)
      begin
        slots_d[pos[i]].res  = lane_res[i].res;
        slots_d[pos[i]].comp = lane_res[i].comp;
      end
    end
  end

  ////////////////////////////////////////
  // CSR register
  ////////////////////////////////////////

  // Ascending scan, highest writing lane wins
  always_comb
  begin
    csr_next = csr_q;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (lane_res[i].csr_wr)
        csr_next = lane_res[i].csr_new;
    end
  end

  assign csr_value = csr_q;
  assign csr_out   = csr_q;

  ////////////////////////////////////////
  // Stage 3 register
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    wb_slots <= slots_d;
    if (rst)
    begin
      s2_strobe <= 1'b0;
      wb_strobe <= 1'b0;
      wb_count  <= '0;
      csr_q     <= '0;
    end
    else
    begin
      s2_strobe <= disp_strobe;
      // Empty packets still retire
      wb_strobe <= s2_strobe;
      wb_count  <= cnt_d;
      csr_q     <= csr_next;
    end
  end

endmodule

/* rtl/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane
(
  input  logic                       clk,
  input  logic                       rst,
  input  exec_pkg::lane_ctl_t        ctl,
  // Current CSR from retire, sampled in stage 2
  input  logic [exec_pkg::XLEN-1:0]  csr_value,
  output exec_pkg::lane_res_t        result
);

  logic [exec_pkg::XLEN-1:0] alu_res;
  logic                      alu_comp;
  logic [exec_pkg::XLEN-1:0] alu_csr;

  exec_alu u_alu (
    .ctl     (ctl),
    .csr_in  (csr_value),
    .res     (alu_res),
    .comp    (alu_comp),
    .csr_new (alu_csr)
  );

  ////////////////////////////////////////
  // Stage 2 register
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    // Result payload
    result.res     <= alu_res;
    result.comp    <= alu_comp;
    result.csr_new <= alu_csr;
    if (rst)
    begin
      result.valid  <= 1'b0;
      result.csr_wr <= 1'b0;
    end
    else
    begin
      result.valid  <= ctl.valid;
      // Write request only from a live CSR slot
      result.csr_wr <= ctl.valid && (ctl.csrsel != exec_pkg::CSR_NONE);
    end
  end

endmodule

/* rtl/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu
(
  input  exec_pkg::lane_ctl_t        ctl,
  input  logic [exec_pkg::XLEN-1:0]  csr_in,
  output logic [exec_pkg::XLEN-1:0]  res,
  output logic                       comp,
  output logic [exec_pkg::XLEN-1:0]  csr_new
);

  // Base ALU output
  logic [exec_pkg::XLEN-1:0] s;
  // Unsigned less than
  logic                      ltu;
  // Zero extended low pc bits for auipc
  logic [exec_pkg::XLEN-1:0] pc_low;

  assign ltu    = (ctl.a < ctl.b);
  assign comp   = ltu;
  assign pc_low = {{(exec_pkg::XLEN - 12){1'b0}}, ctl.pc[11:0]};

  ////////////////////////////////////////
  // Arithmetic, logic and shifts
  ////////////////////////////////////////

  always_comb
  begin
    case (ctl.alusel)
      exec_pkg::ALU_ADD: s = ctl.a + ctl.b;
      exec_pkg::ALU_SUB: s = ctl.a - ctl.b;
      exec_pkg::ALU_AND: s = ctl.a & ctl.b;
      exec_pkg::ALU_OR:  s = ctl.a | ctl.b;
      exec_pkg::ALU_XOR: s = ctl.a ^ ctl.b;
      // Shift amount from b[4:0]
      exec_pkg::ALU_SLL: s = ctl.a << ctl.b[4:0];
      exec_pkg::ALU_SRL: s = ctl.a >> ctl.b[4:0];
      // Sign fill from a[31]
      exec_pkg::ALU_SRA: s = $signed(ctl.a) >>> ctl.b[4:0];
      default:           s = ctl.a + ctl.b;
    endcase
  end

  ////////////////////////////////////////
  // CSR update
  ////////////////////////////////////////

  always_comb
  begin
    case (ctl.csrsel)
      exec_pkg::CSR_RW:  csr_new = ctl.a;
      exec_pkg::CSR_RS:  csr_new = csr_in | ctl.a;
      // Clear is a real and-not
      exec_pkg::CSR_RC:  csr_new = csr_in & ~ctl.a;
      // Immediate forms take b
      exec_pkg::CSR_RWI: csr_new = ctl.b;
      exec_pkg::CSR_RSI: csr_new = csr_in | ctl.b;
      exec_pkg::CSR_RCI: csr_new = csr_in & ~ctl.b;
      default:           csr_new = csr_in;
    endcase
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb
  begin
    // CSR forms hand back the old value
    if (ctl.csrsel != exec_pkg::CSR_NONE)
      res = csr_in;
    else if (ctl.lui)
      res = ctl.b;
    else if (ctl.auipc)
      res = ctl.b + pc_low;
    // Link address
    else if (ctl.jal || ctl.jalr)
      res = ctl.pc + 32'd4;
    // Compare gives 0 or 1
    else if (ctl.compare)
      res = {{(exec_pkg::XLEN - 1){1'b0}}, ltu};
    else
      res = s;
  end

endmodule

/* rtl/exec_dispatch.sv */
`timescale 1ns/1ps

module exec_dispatch #(
  parameter int NUM_LANES = 4
)
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   issue_strobe,
  input  exec_pkg::exec_slot_t [NUM_LANES-1:0]   issue_slots,
  output exec_pkg::lane_ctl_t  [NUM_LANES-1:0]   lane_ctl,
  // Stage 1 packet marker, also set for an empty strobe
  output logic                                   disp_strobe
);

  ////////////////////////////////////////
  // Slot decode
  ////////////////////////////////////////

  function automatic exec_pkg::lane_ctl_t decode_slot(input exec_pkg::exec_slot_t slot,
                                                      input logic strobe);
    exec_pkg::lane_ctl_t c;
    c = '0;
    // Slot only counts while the packet strobe is up
    c.valid = strobe && slot.valid;
    c.a     = slot.a;
    c.b     = slot.b;
    c.pc    = slot.pc;
    case (slot.kind)
      exec_pkg::ADD:   c.alusel = exec_pkg::ALU_ADD;
      exec_pkg::SUB:   c.alusel = exec_pkg::ALU_SUB;
      exec_pkg::AND:   c.alusel = exec_pkg::ALU_AND;
      exec_pkg::OR:    c.alusel = exec_pkg::ALU_OR;
      exec_pkg::XOR:   c.alusel = exec_pkg::ALU_XOR;
      exec_pkg::SLL:   c.alusel = exec_pkg::ALU_SLL;
      exec_pkg::SRL:   c.alusel = exec_pkg::ALU_SRL;
      exec_pkg::SRA:   c.alusel = exec_pkg::ALU_SRA;
      // Compare rides on the subtractor select
      exec_pkg::SLTU:
      begin
        c.alusel  = exec_pkg::ALU_SUB;
        c.compare = 1'b1;
      end
      exec_pkg::LUI:   c.lui    = 1'b1;
      exec_pkg::AUIPC: c.auipc  = 1'b1;
      exec_pkg::JAL:   c.jal    = 1'b1;
      exec_pkg::JALR:  c.jalr   = 1'b1;
      // Register source CSR forms only
      exec_pkg::CSRRW: c.csrsel = exec_pkg::CSR_RW;
      exec_pkg::CSRRS: c.csrsel = exec_pkg::CSR_RS;
      exec_pkg::CSRRC: c.csrsel = exec_pkg::CSR_RC;
      default:         c.alusel = exec_pkg::ALU_ADD;
    endcase
    return c;
  endfunction

  exec_pkg::lane_ctl_t [NUM_LANES-1:0] ctl_d;

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      ctl_d[i] = decode_slot(issue_slots[i], issue_strobe);
    end
  end

  ////////////////////////////////////////
  // Stage 1 register
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    // Operands and decode fields
    lane_ctl <= ctl_d;
    if (rst)
    begin
      disp_strobe <= 1'b0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
        lane_ctl[i].valid <= 1'b0;
      end
    end
    else
    begin
      disp_strobe <= issue_strobe;
    end
  end

endmodule

/* rtl/exec_pkg.sv */
package exec_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Datapath width, decode assumes 32 bits
  localparam int XLEN = 32;

  ////////////////////////////////////////
  // Operation kinds
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    AND   = 4'd2,
    OR    = 4'd3,
    XOR   = 4'd4,
    SLL   = 4'd5,
    SRL   = 4'd6,
    SRA   = 4'd7,
    SLTU  = 4'd8,
    LUI   = 4'd9,
    AUIPC = 4'd10,
    JAL   = 4'd11,
    JALR  = 4'd12,
    CSRRW = 4'd13,
    CSRRS = 4'd14,
    CSRRC = 4'd15
  } exec_kind_e;

  // ALU select codes
  localparam logic [2:0] ALU_ADD = 3'b000;
  localparam logic [2:0] ALU_SUB = 3'b001;
  localparam logic [2:0] ALU_AND = 3'b010;
  localparam logic [2:0] ALU_OR  = 3'b011;
  localparam logic [2:0] ALU_XOR = 3'b100;
  localparam logic [2:0] ALU_SLL = 3'b101;
  localparam logic [2:0] ALU_SRL = 3'b110;
  localparam logic [2:0] ALU_SRA = 3'b111;

  // CSR update forms, bit 2 picks the immediate in b
  localparam logic [2:0] CSR_NONE = 3'b000;
  localparam logic [2:0] CSR_RW   = 3'b001;
  localparam logic [2:0] CSR_RS   = 3'b010;
  localparam logic [2:0] CSR_RC   = 3'b011;
  localparam logic [2:0] CSR_RWI  = 3'b101;
  localparam logic [2:0] CSR_RSI  = 3'b110;
  localparam logic [2:0] CSR_RCI  = 3'b111;

  ////////////////////////////////////////
  // Packets
  ////////////////////////////////////////

  // One issue slot
  typedef struct packed {
    logic            valid;
    exec_kind_e      kind;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] pc;
  } exec_slot_t;

  // Decoded controls for one lane
  typedef struct packed {
    logic            valid;
    logic [2:0]      alusel;
    logic            lui;
    logic            auipc;
    logic            jal;
    logic            jalr;
    logic            compare;
    logic [2:0]      csrsel;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] pc;
  } lane_ctl_t;

  // Registered lane output
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] res;
    logic            comp;
    logic            csr_wr;
    logic [XLEN-1:0] csr_new;
  } lane_res_t;

  // Write-back entry
  typedef struct packed {
    logic [XLEN-1:0] res;
    logic            comp;
  } wb_slot_t;

endpackage
